// ==== verilog.f ====
logic/msu_pkg.sv
logic/bus_strobe_sync.sv
logic/mcu_cmd_sync.sv
logic/msu_databuf.sv
logic/msu_regs.sv
logic/msu_top.sv
sim/msu_checker.sv
sim/msu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module msu_tb -f verilog.f -o msu_sim \
  && ./obj_dir/msu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "Build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -qx "TB PASSED" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/msu_tb.sv ====
module msu_tb
  import msu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SYNC_STAGES  = 2;
  localparam int HOLD         = SYNC_STAGES + 4;  // Cycles per strobe phase
  localparam int OP_CYCLES    = 2 * HOLD + 2;
  localparam int N_OPS        = 40;               // Bus and MCU operations
  localparam int FILL_LEN     = 16;
  localparam int LIMIT_CYCLES = N_OPS * OP_CYCLES + 2 * FILL_LEN + 200;

  logic       clkin;
  logic       arst_n;
  logic       enable;
  logic       rd_n;
  logic       wr_n;
  reg_idx_t   reg_idx;
  byte_t      wr_data;
  byte_t      rd_data_out;
  logic       pgm_we;
  buf_addr_t  pgm_addr;
  byte_t      pgm_data;
  logic       status_we;
  logic       addr_we;
  flag_bits_t set_bits;
  flag_bits_t clr_bits;
  buf_addr_t  load_addr;
  seek_addr_t seek_addr;
  track_t     track;
  byte_t      volume;
  logic       volume_latch;
  byte_t      status_out;

  // Reference model
  buf_addr_t  exp_ptr;
  seek_addr_t exp_seek;
  track_t     exp_track;
  byte_t      exp_vol;
  flag_bits_t exp_flags;  // Same bit order as the MCU mask
  logic       exp_audio_start;
  logic       exp_data_start;
  logic [2:0] exp_ctrl;
  byte_t      exp_mem [16384];
  int         errors;
  logic [31:0] lcg_state;
  string      id_str = "S-MSU1";

  msu_top #(.SYNC_STAGES(SYNC_STAGES)) DUT (.*);

  bind msu_top msu_checker u_chk (
    .clkin        (clkin),
    .arst_n       (arst_n),
    .enable       (enable),
    .reg_idx      (reg_idx),
    .pulses       (pulses),
    .cmd          (cmd),
    .ptr          (buf_rd_addr),
    .volume_latch (volume_latch),
    .status_out   (status_out)
  );

  initial begin
    clkin = 1'b0;
    forever #10 clkin = ~clkin;
  end

  function automatic byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];  // Upper bits are the most random
  endfunction

  function automatic byte_t exp_status_rd();
    return {exp_flags[4], exp_flags[5], exp_flags[2:1], exp_flags[3], 3'b010};
  endfunction

  function automatic byte_t exp_status_out();
    return {exp_ptr[13], exp_audio_start, exp_data_start, 1'b0, exp_ctrl, exp_flags[0]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_value("seek_addr", seek_addr, exp_seek);
    check_value("track", track, exp_track);
    check_value("volume", volume, exp_vol);
    check_value("status_out", status_out, exp_status_out());
  endtask

  task automatic bus_read(input reg_idx_t idx, output byte_t data);
    @(posedge clkin);
    reg_idx <= idx;
    rd_n    <= 1'b0;
    repeat (HOLD) @(posedge clkin);
    rd_n <= 1'b1;
    repeat (HOLD) @(posedge clkin);
    @(negedge clkin);
    data = rd_data_out;
    if (enable && idx == REG_DATA) exp_ptr = exp_ptr + 14'd1;
  endtask

  task automatic bus_write(input reg_idx_t idx, input byte_t data);
    @(posedge clkin);
    reg_idx <= idx;
    wr_data <= data;
    wr_n    <= 1'b0;
    repeat (HOLD) @(posedge clkin);
    wr_n <= 1'b1;
    repeat (HOLD) @(posedge clkin);
    @(negedge clkin);
    if (enable) begin
      case (idx)
        REG_SEEK0:  exp_seek[7:0]   = data;
        REG_SEEK1:  exp_seek[15:8]  = data;
        REG_SEEK2:  exp_seek[23:16] = data;
        REG_SEEK3: begin
          exp_seek[31:24] = data;
          exp_data_start  = 1'b1;
          exp_flags[4]    = 1'b1;
        end
        REG_TRACK0: exp_track[7:0] = data;
        REG_TRACK1: begin
          exp_track[15:8] = data;
          exp_audio_start = 1'b1;
          exp_flags[5]    = 1'b1;
        end
        REG_VOLUME: exp_vol = data;
        default: begin
          if (!exp_flags[5]) begin  // Control only while audio is idle
            exp_ctrl     = data[2:0];
            exp_flags[0] = 1'b1;
          end
        end
      endcase
    end
  endtask

  task automatic mcu_status(input flag_bits_t set, input flag_bits_t clr);
    @(posedge clkin);
    set_bits  <= set;
    clr_bits  <= clr;
    status_we <= 1'b1;
    repeat (HOLD) @(posedge clkin);
    status_we <= 1'b0;
    repeat (HOLD) @(posedge clkin);
    @(negedge clkin);
    for (int b = 0; b < 6; b++) begin
      if (clr[b]) begin
        exp_flags[b] = 1'b0;  // Clear beats set
      end else if (set[b]) begin
        exp_flags[b] = 1'b1;
      end
    end
    if (clr[5]) exp_audio_start = 1'b0;
    if (clr[4]) exp_data_start = 1'b0;
  endtask

  task automatic mcu_load_addr(input buf_addr_t addr);
    @(posedge clkin);
    load_addr <= addr;
    addr_we   <= 1'b1;
    repeat (HOLD) @(posedge clkin);
    addr_we <= 1'b0;
    repeat (HOLD) @(posedge clkin);
    @(negedge clkin);
    exp_ptr = addr;
  endtask

  // Watchdog
  initial begin
    repeat (LIMIT_CYCLES) @(posedge clkin);
    $display("Timeout: run did not finish within %0d clock cycles", LIMIT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    byte_t       rd;
    byte_t       exp;
    byte_t       ctrl_val;
    buf_addr_t   addr;
    int unsigned chk_fails;

    arst_n = 1'b0;
    enable = 1'b1;
    rd_n = 1'b1;
    wr_n = 1'b1;
    reg_idx = '0;
    wr_data = '0;
    pgm_we = 1'b0;
    pgm_addr = '0;
    pgm_data = '0;
    status_we = 1'b0;
    addr_we = 1'b0;
    set_bits = '0;
    clr_bits = '0;
    load_addr = '0;
    errors = 0;
    lcg_state = 32'h8bd88e0b;
    exp_ptr = '0;
    exp_seek = '0;
    exp_track = '0;
    exp_vol = '0;
    exp_flags = 6'b110000;  // Both busy after reset
    exp_audio_start = 1'b0;
    exp_data_start = 1'b0;
    exp_ctrl = '0;
    repeat (3) @(posedge clkin);
    arst_n <= 1'b1;

    // State after reset
    bus_read(REG_STATUS, rd);
    check_value("status read", rd, exp_status_rd());
    check_outputs();
    check_value("volume_latch", volume_latch, 1'b0);

    for (int i = 0; i < 6; i++) begin
      bus_read(reg_idx_t'(i + 2), rd);
      check_value("identifier byte", rd, id_str[i]);
    end

    ////////////////////////////////////////
    // Streaming across the wrap point
    ////////////////////////////////////////
    for (int i = 0; i < FILL_LEN; i++) begin
      addr = 14'h3FF8 + buf_addr_t'(i);
      exp_mem[addr] = rand_byte();
      @(posedge clkin);
      pgm_we   <= 1'b1;
      pgm_addr <= addr;
      pgm_data <= exp_mem[addr];
    end
    @(posedge clkin);
    pgm_we <= 1'b0;
    mcu_load_addr(14'h3FFC);
    check_outputs();
    for (int i = 0; i < 8; i++) begin
      exp = exp_mem[exp_ptr];
      bus_read(REG_DATA, rd);
      check_value("data read", rd, exp);
      check_outputs();
    end

    // Seek, track, volume
    for (int i = 0; i < 7; i++) begin
      bus_write(reg_idx_t'(i), rand_byte());
      check_outputs();
    end

    // MCU services both requests, then flags an error
    mcu_status(6'b000000, 6'b110000);
    check_outputs();
    bus_read(REG_STATUS, rd);
    check_value("status after clear", rd, exp_status_rd());
    mcu_status(6'b001000, 6'b000000);
    bus_read(REG_STATUS, rd);
    check_value("status after set", rd, exp_status_rd());

    ////////////////////////////////////////
    // Control gating and enable
    ////////////////////////////////////////
    ctrl_val = rand_byte();
    bus_write(REG_TRACK1, rand_byte());
    bus_write(REG_CTRL, ctrl_val);  // Ignored while audio is busy
    check_outputs();
    mcu_status(6'b000000, 6'b100000);
    bus_write(REG_CTRL, ctrl_val);
    check_outputs();
    @(posedge clkin);
    enable <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      bus_write(reg_idx_t'(i), rand_byte());
      check_outputs();
    end

    chk_fails = DUT.u_chk.fail_cnt;
    $display("Errors: %0d model mismatches, %0d assertion failures", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/msu_checker.sv ====
module msu_checker
  import msu_pkg::*;
(
  input logic        clkin,
  input logic        arst_n,
  input logic        enable,
  input reg_idx_t    reg_idx,
  input bus_pulses_t pulses,
  input mcu_cmd_t    cmd,
  input buf_addr_t   ptr,
  input logic        volume_latch,
  input byte_t       status_out
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;
  logic        vol_wr;
  logic        ptr_move;

  assign vol_wr   = pulses.wr_end & enable & (reg_idx == REG_VOLUME);
  assign ptr_move = cmd.addr_load | (pulses.rd_end & enable & (reg_idx == REG_DATA));

  ////////////////////////////////////////
  // Volume latch
  ////////////////////////////////////////
  latch_single: assert property (@(posedge clkin) disable iff (!arst_n)
    volume_latch |=> !volume_latch)
  else begin
    fail_cnt++;
    $error("volume_latch stayed high for two cycles");
  end

  // Volume start bit of the MCU status rises with the latch
  latch_follows_write: assert property (@(posedge clkin) disable iff (!arst_n)
    vol_wr |=> volume_latch && status_out[4])
  else begin
    fail_cnt++;
    $error("volume write not followed by volume_latch and status_out bit 4");
  end

  latch_needs_write: assert property (@(posedge clkin) disable iff (!arst_n)
    volume_latch |-> $past(vol_wr))
  else begin
    fail_cnt++;
    $error("volume_latch pulse without a volume write");
  end

  ////////////////////////////////////////
  // Buffer pointer
  ////////////////////////////////////////
  ptr_moves_on_cmd: assert property (@(posedge clkin) disable iff (!arst_n)
    (ptr != $past(ptr)) |-> $past(ptr_move))
  else begin
    fail_cnt++;
    $error("buffer pointer moved without rd_end or addr_load");
  end

endmodule

// ==== logic/msu_top.sv ====
module msu_top
  import msu_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clkin,
  input  logic       arst_n,
  input  logic       enable,
  // Console bus
  input  logic       rd_n,
  input  logic       wr_n,
  input  reg_idx_t   reg_idx,
  input  byte_t      wr_data,
  output byte_t      rd_data_out,
  // MCU buffer fill
  input  logic       pgm_we,
  input  buf_addr_t  pgm_addr,
  input  byte_t      pgm_data,
  // MCU status and pointer control
  input  logic       status_we,
  input  logic       addr_we,
  input  flag_bits_t set_bits,
  input  flag_bits_t clr_bits,
  input  buf_addr_t  load_addr,
  // To MCU and audio side
  output seek_addr_t seek_addr,
  output track_t     track,
  output byte_t      volume,
  output logic       volume_latch,
  output byte_t      status_out
);

  bus_pulses_t pulses;
  mcu_cmd_t    cmd;
  buf_addr_t   buf_rd_addr;
  byte_t       buf_rd_data;

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////
  bus_strobe_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_bus_sync (
    .clkin  (clkin),
    .arst_n (arst_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .pulses (pulses)
  );

  mcu_cmd_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_mcu_sync (
    .clkin     (clkin),
    .arst_n    (arst_n),
    .status_we (status_we),
    .addr_we   (addr_we),
    .set_bits  (set_bits),
    .clr_bits  (clr_bits),
    .load_addr (load_addr),
    .cmd       (cmd)
  );

  ////////////////////////////////////////
  // Register file and buffer
  ////////////////////////////////////////
  msu_regs u_regs (
    .clkin        (clkin),
    .arst_n       (arst_n),
    .enable       (enable),
    .reg_idx      (reg_idx),
    .wr_data      (wr_data),
    .pulses       (pulses),
    .cmd          (cmd),
    .buf_rd_addr  (buf_rd_addr),
    .buf_rd_data  (buf_rd_data),
    .rd_data_out  (rd_data_out),
    .seek_addr    (seek_addr),
    .track        (track),
    .volume       (volume),
    .volume_latch (volume_latch),
    .status_out   (status_out)
  );

  msu_databuf u_databuf (
    .clkin    (clkin),
    .pgm_we   (pgm_we),
    .pgm_addr (pgm_addr),
    .pgm_data (pgm_data),
    .rd_addr  (buf_rd_addr),
    .rd_data  (buf_rd_data)
  );

endmodule

// ==== logic/msu_regs.sv ====
module msu_regs
  import msu_pkg::*;
(
  input  logic        clkin,
  input  logic        arst_n,
  input  logic        enable,
  input  reg_idx_t    reg_idx,
  input  byte_t       wr_data,
  input  bus_pulses_t pulses,
  input  mcu_cmd_t    cmd,
  output buf_addr_t   buf_rd_addr,
  input  byte_t       buf_rd_data,
  output byte_t       rd_data_out,
  output seek_addr_t  seek_addr,
  output track_t      track,
  output byte_t       volume,
  output logic        volume_latch,
  output byte_t       status_out
);

  // Qualified bus events
  logic       wr_en;
  logic       rd_go;
  logic       rd_done;

  buf_addr_t  ptr;
  byte_t      rd_mux;
  byte_t      rd_q;
  byte_t      status_byte;

  seek_addr_t seek_q;
  track_t     track_q;
  byte_t      vol_q;
  logic       vol_latch_q;

  // Flags the MCU can touch
  logic       audio_busy;
  logic       data_busy;
  logic       audio_err;
  logic [1:0] audio_stat;
  logic       ctrl_start;
  flag_bits_t cur_flags;
  flag_bits_t upd_flags;

  logic       audio_start;
  logic       data_start;
  logic [2:0] ctrl_bits;

  assign wr_en   = pulses.wr_end & enable;
  assign rd_go   = pulses.rd_start & enable;
  assign rd_done = pulses.rd_end & enable & (reg_idx == REG_DATA);

  ////////////////////////////////////////
  // Buffer pointer
  ////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= '0;
    end else if (cmd.addr_load) begin
      ptr <= cmd.load_addr;  // MCU reposition wins
    end else if (rd_done) begin
      ptr <= ptr + 1'b1;     // Wraps at 3FFF
    end
  end

  assign buf_rd_addr = ptr;

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////
  assign status_byte = {data_busy, audio_busy, audio_stat, audio_err, STATUS_FIXED};

  always_comb begin
    case (reg_idx)
      REG_STATUS: rd_mux = status_byte;
      REG_DATA:   rd_mux = buf_rd_data;  // Settled long before rd_start
      REG_ID0:    rd_mux = MSU_ID[0];
      REG_ID1:    rd_mux = MSU_ID[1];
      REG_ID2:    rd_mux = MSU_ID[2];
      REG_ID3:    rd_mux = MSU_ID[3];
      REG_ID4:    rd_mux = MSU_ID[4];
      REG_ID5:    rd_mux = MSU_ID[5];
      default:    rd_mux = '0;
    endcase
  end

  // Holds until the next read starts
  always_ff @(posedge clkin) begin
    if (rd_go) rd_q <= rd_mux;
  end

  assign rd_data_out = rd_q;

  ////////////////////////////////////////
  // Write path and status flags
  ////////////////////////////////////////
  assign cur_flags = {audio_busy, data_busy, audio_err, audio_stat, ctrl_start};
  assign upd_flags = (cur_flags | cmd.set_bits) & ~cmd.clr_bits;  // Clear wins

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      seek_q      <= '0;
      track_q     <= '0;
      vol_q       <= '0;
      vol_latch_q <= 1'b0;
      audio_busy  <= 1'b1;
      data_busy   <= 1'b1;
      audio_err   <= 1'b0;
      audio_stat  <= '0;
      ctrl_start  <= 1'b0;
      audio_start <= 1'b0;
      data_start  <= 1'b0;
      ctrl_bits   <= '0;
    end else begin
      vol_latch_q <= 1'b0;
      if (wr_en) begin
        // A status update arriving here is dropped
        case (reg_idx)
          REG_SEEK0:  seek_q[7:0]   <= wr_data;
          REG_SEEK1:  seek_q[15:8]  <= wr_data;
          REG_SEEK2:  seek_q[23:16] <= wr_data;
          REG_SEEK3: begin
            seek_q[31:24] <= wr_data;
            data_start    <= 1'b1;
            data_busy     <= 1'b1;
          end
          REG_TRACK0: track_q[7:0] <= wr_data;
          REG_TRACK1: begin
            track_q[15:8] <= wr_data;
            audio_start   <= 1'b1;
            audio_busy    <= 1'b1;
          end
          REG_VOLUME: begin
            vol_q       <= wr_data;
            vol_latch_q <= 1'b1;
          end
          REG_CTRL: begin
            if (!audio_busy) begin  // Ignored while a track loads
              ctrl_bits  <= wr_data[2:0];
              ctrl_start <= 1'b1;
            end
          end
          default: ;
        endcase
      end else if (cmd.status_upd) begin
        audio_busy <= upd_flags[FLAG_AUDIO_BUSY];
        data_busy  <= upd_flags[FLAG_DATA_BUSY];
        audio_err  <= upd_flags[FLAG_AUDIO_ERR];
        audio_stat <= upd_flags[FLAG_AUDIO_STAT +: 2];
        ctrl_start <= upd_flags[FLAG_CTRL_START];
        // Serviced request drops its start flag
        if (cmd.clr_bits[FLAG_AUDIO_BUSY]) audio_start <= 1'b0;
        if (cmd.clr_bits[FLAG_DATA_BUSY])  data_start  <= 1'b0;
      end
    end
  end

  assign seek_addr    = seek_q;
  assign track        = track_q;
  assign volume       = vol_q;
  assign volume_latch = vol_latch_q;

  // MCU view of pending requests
  assign status_out = {ptr[$bits(buf_addr_t)-1], audio_start, data_start,
                       vol_latch_q, ctrl_bits, ctrl_start};

endmodule

// ==== logic/msu_databuf.sv ====
module msu_databuf
  import msu_pkg::*;
(
  input  logic      clkin,
  input  logic      pgm_we,
  input  buf_addr_t pgm_addr,
  input  byte_t     pgm_data,
  input  buf_addr_t rd_addr,
  output byte_t     rd_data
);

  localparam int DEPTH = 2 ** $bits(buf_addr_t);

  byte_t mem [DEPTH];
  byte_t rd_q;

  ////////////////////////////////////////
  // Simple dual port, one clock
  ////////////////////////////////////////
  always_ff @(posedge clkin) begin
    if (pgm_we) begin
      mem[pgm_addr] <= pgm_data;  // MCU fill port
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clkin) begin
    rd_q <= mem[rd_addr];
  end

  assign rd_data = rd_q;

endmodule

// ==== logic/mcu_cmd_sync.sv ====
module mcu_cmd_sync
  import msu_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clkin,
  input  logic       arst_n,
  input  logic       status_we,
  input  logic       addr_we,
  input  flag_bits_t set_bits,
  input  flag_bits_t clr_bits,
  input  buf_addr_t  load_addr,
  output mcu_cmd_t   cmd
);

  localparam int ST = 0;  // status_we lane
  localparam int AD = 1;  // addr_we lane

  logic [SYNC_STAGES:0][1:0] sh;
  logic [1:0]                rise;
  logic                      upd_q;
  logic                      load_q;
  flag_bits_t                set_q;
  flag_bits_t                clr_q;
  buf_addr_t                 addr_q;

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      sh <= '0;  // MCU strobes idle low
    end else begin
      sh <= {sh[SYNC_STAGES-1:0], {addr_we, status_we}};
    end
  end

  assign rise = sh[SYNC_STAGES-1] & ~sh[SYNC_STAGES];

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      upd_q  <= 1'b0;
      load_q <= 1'b0;
    end else begin
      upd_q  <= rise[ST];
      load_q <= rise[AD];
    end
  end

  // Operands are held steady by the MCU around its strobe
  always_ff @(posedge clkin) begin
    if (rise[ST]) begin
      set_q <= set_bits;
      clr_q <= clr_bits;
    end
    if (rise[AD]) addr_q <= load_addr;
  end

  assign cmd = '{status_upd: upd_q, addr_load: load_q, set_bits: set_q,
                 clr_bits: clr_q, load_addr: addr_q};

endmodule

// ==== logic/bus_strobe_sync.sv ====
module bus_strobe_sync
  import msu_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic        clkin,
  input  logic        arst_n,
  input  logic        rd_n,
  input  logic        wr_n,
  output bus_pulses_t pulses
);

  // Lane positions in the shared chain
  localparam int RD = 0;
  localparam int WR = 1;

  // Stage 0 is the first flop, stage SYNC_STAGES holds history
  logic [SYNC_STAGES:0][1:0] sh;
  logic [1:0]                cur;
  logic [1:0]                prev;
  logic                      rd_fall;
  logic                      rd_rise;
  logic                      wr_rise;
  bus_pulses_t               pulses_q;

  ////////////////////////////////////////
  // Synchronizer chain
  ////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      sh <= '1;  // Strobes idle high
    end else begin
      sh <= {sh[SYNC_STAGES-1:0], {wr_n, rd_n}};
    end
  end

  assign cur  = sh[SYNC_STAGES-1];
  assign prev = sh[SYNC_STAGES];

  ////////////////////////////////////////
  // Edge detect
  ////////////////////////////////////////
  assign rd_fall = prev[RD] & ~cur[RD];
  assign rd_rise = ~prev[RD] & cur[RD];
  assign wr_rise = ~prev[WR] & cur[WR];  // Write completes on release

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      pulses_q <= '0;
    end else begin
      pulses_q.rd_start <= rd_fall;
      pulses_q.rd_end   <= rd_rise;
      pulses_q.wr_end   <= wr_rise;
    end
  end

  assign pulses = pulses_q;

endmodule

// ==== logic/msu_pkg.sv ====
package msu_pkg;

  ////////////////////////////////////////
  // Width types
  ////////////////////////////////////////
  typedef logic [7:0]  byte_t;
  typedef logic [13:0] buf_addr_t;   // 16 KiB data buffer
  typedef logic [2:0]  reg_idx_t;
  typedef logic [31:0] seek_addr_t;
  typedef logic [15:0] track_t;
  typedef logic [5:0]  flag_bits_t;  // MCU status update mask

  // Positions inside flag_bits_t
  localparam int FLAG_AUDIO_BUSY = 5;
  localparam int FLAG_DATA_BUSY  = 4;
  localparam int FLAG_AUDIO_ERR  = 3;
  localparam int FLAG_AUDIO_STAT = 1;  // Two bits wide, 2..1
  localparam int FLAG_CTRL_START = 0;

  typedef struct packed {
    logic rd_start;   // Falling edge of rd_n
    logic rd_end;     // Rising edge of rd_n
    logic wr_end;     // Rising edge of wr_n
  } bus_pulses_t;

  typedef struct packed {
    logic       status_upd;
    logic       addr_load;
    flag_bits_t set_bits;
    flag_bits_t clr_bits;
    buf_addr_t  load_addr;
  } mcu_cmd_t;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////
  // Read side
  localparam reg_idx_t REG_STATUS = 3'd0;
  localparam reg_idx_t REG_DATA   = 3'd1;
  localparam reg_idx_t REG_ID0    = 3'd2;
  localparam reg_idx_t REG_ID1    = 3'd3;
  localparam reg_idx_t REG_ID2    = 3'd4;
  localparam reg_idx_t REG_ID3    = 3'd5;
  localparam reg_idx_t REG_ID4    = 3'd6;
  localparam reg_idx_t REG_ID5    = 3'd7;

  // Write side
  localparam reg_idx_t REG_SEEK0  = 3'd0;
  localparam reg_idx_t REG_SEEK1  = 3'd1;
  localparam reg_idx_t REG_SEEK2  = 3'd2;
  localparam reg_idx_t REG_SEEK3  = 3'd3;
  localparam reg_idx_t REG_TRACK0 = 3'd4;
  localparam reg_idx_t REG_TRACK1 = 3'd5;
  localparam reg_idx_t REG_VOLUME = 3'd6;
  localparam reg_idx_t REG_CTRL   = 3'd7;

  // "S-MSU1"
  localparam byte_t MSU_ID [6] = '{8'h53, 8'h2D, 8'h4D, 8'h53, 8'h55, 8'h31};

  localparam logic [2:0] STATUS_FIXED = 3'b010;  // Low bits of status read

endpackage
